// ==== tb.f ====
verilog/dcache_pkg.sv
verilog/dcache_ifs.sv
verilog/dcache_lookup.sv
verilog/dcache_bus.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
testbench/dcache_asserts.sv
testbench/dcache_tb.sv

// ==== Bender.yml ====
# Direct mapped write-back data cache.
package:
  name: dcache

sources:
  - verilog/dcache_pkg.sv
  - verilog/dcache_ifs.sv
  - verilog/dcache_lookup.sv
  - verilog/dcache_bus.sv
  - verilog/dcache_ctrl.sv
  - verilog/dcache_top.sv
  - target: test
    files:
      - testbench/dcache_asserts.sv
      - testbench/dcache_tb.sv

// ==== testbench/dcache_tb.sv ====
//**************************************************************************
// Data cache testbench.
// Directed tests against a memory model with random slave busy.
//**************************************************************************

`timescale 1ns/1ps

module dcache_tb;
	import dcache_pkg::*;

	localparam int TIMEOUT_CYCLES = 2000; // About four times the full run.
	localparam int MEM_WORDS      = 1 << ADDR_W;

	// Set index is the low two address bits.
	localparam logic [ADDR_W-1:0] SET_BASE = 15'h1230;
	localparam logic [ADDR_W-1:0] ADDR_A1  = 15'h1231;
	localparam logic [ADDR_W-1:0] ADDR_B2  = 15'h2a42;
	localparam logic [ADDR_W-1:0] ADDR_C1  = 15'h0755;
	localparam logic [ADDR_W-1:0] ADDR_D2  = 15'h3336;
	localparam logic [ADDR_W-1:0] ADDR_E3  = 15'h4447;
	localparam logic [ADDR_W-1:0] ADDR_F3  = 15'h5553;

	logic              clk_i;
	logic              rst_i;
	logic              conly_i;
	logic              cmiss_i;
	logic              m_wb_cyc_i;
	logic              m_wb_stb_i;
	logic              m_wb_we_i;
	logic [ADDR_W-1:0] m_wb_addr_i;
	logic [SEL_W-1:0]  m_wb_sel_i;
	logic [ARCH_W-1:0] m_wb_dat_i;
	logic              m_wb_bsy_o;
	logic              m_wb_ack_o;
	logic [ARCH_W-1:0] m_wb_dat_o;
	logic              s_wb_cyc_o;
	logic              s_wb_stb_o;
	logic              s_wb_we_o;
	logic [ADDR_W-1:0] s_wb_addr_o;
	logic [SEL_W-1:0]  s_wb_sel_o;
	logic [ARCH_W-1:0] s_wb_dat_o;
	logic              s_wb_bsy_i;
	logic              s_wb_ack_i;
	logic [ARCH_W-1:0] s_wb_dat_i;

	logic [ARCH_W-1:0] mem    [MEM_WORDS]; // Memory model contents.
	logic [ARCH_W-1:0] shadow [MEM_WORDS]; // Word a coherent cache must return.
	logic              log_we   [256];     // One entry per slave cycle.
	logic [ADDR_W-1:0] log_addr [256];
	logic [SEL_W-1:0]  log_sel  [256];
	logic [ARCH_W-1:0] log_dat  [256];
	int                slave_cnt = 0;
	int                cycle_cnt = 0;
	integer            seed = 32'ha74e9d03;

	dcache_top uut (.*);

	function automatic logic [ARCH_W-1:0] init_word(input logic [ADDR_W-1:0] addr);
		return {addr, 1'b1} ^ 16'h6c35;
	endfunction

	function automatic logic [ARCH_W-1:0] apply_sel(input logic [ARCH_W-1:0] old_w,
		input logic [ARCH_W-1:0] new_w, input logic [SEL_W-1:0] sel);
		logic [ARCH_W-1:0] res;
		res = old_w;
		for (int b = 0; b < SEL_W; b++) begin
			if (sel[b])
				res[b*8 +: 8] = new_w[b*8 +: 8];
		end
		return res;
	endfunction

	task automatic abort_run();
		$display("Testbench failed");
		$fatal(1, "Run stopped at the first failure.");
	endtask

	task automatic check_true(input bit cond, input string what);
		if (!cond) begin
			$display("Failure at %0t ns: %s", $time, what);
			abort_run();
		end
	endtask

	task automatic check_dat(input logic [ARCH_W-1:0] act, input logic [ARCH_W-1:0] exp,
		input string what);
		if (act !== exp) begin
			$display("Error at %0t ns: %s is %h, expected %h", $time, what, act, exp);
			abort_run();
		end
	endtask

	task automatic check_addr(input logic [ADDR_W-1:0] act, input logic [ADDR_W-1:0] exp,
		input string what);
		if (act !== exp) begin
			$display("Error at %0t ns: %s is %h, expected %h", $time, what, act, exp);
			abort_run();
		end
	endtask

	task automatic check_sel(input logic [SEL_W-1:0] act, input logic [SEL_W-1:0] exp,
		input string what);
		if (act !== exp) begin
			$display("Error at %0t ns: %s is %b, expected %b", $time, what, act, exp);
			abort_run();
		end
	endtask

	task automatic check_cycles(input int act, input int exp, input string what);
		if (act != exp) begin
			$display("Error at %0t ns: %s is %0d, expected %0d", $time, what, act, exp);
			abort_run();
		end
	endtask

	initial begin
		clk_i = 1'b0;
		forever #50 clk_i = ~clk_i;
	end

	always @(posedge clk_i) begin
		cycle_cnt++;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			abort_run();
		end
	end

	// Protocol assertion failures end the run at once.
	always @(uut.u_asserts.fail_cnt) begin
		if (uut.u_asserts.fail_cnt != 0) begin
			$display("Protocol assertion failed at %0t ns", $time);
			abort_run();
		end
	end

	// Memory model that acks one cycle after a random busy period.
	initial begin
		int busy_len;
		s_wb_bsy_i = 1'b0;
		s_wb_ack_i = 1'b0;
		s_wb_dat_i = '0;
		for (int a = 0; a < MEM_WORDS; a++) begin
			mem[a]    = init_word(ADDR_W'(a));
			shadow[a] = mem[a];
		end
		forever begin
			@(posedge clk_i);
			#1;
			if (s_wb_cyc_o && s_wb_stb_o) begin
				log_we[slave_cnt]   = s_wb_we_o;
				log_addr[slave_cnt] = s_wb_addr_o;
				log_sel[slave_cnt]  = s_wb_sel_o;
				log_dat[slave_cnt]  = s_wb_dat_o;
				slave_cnt++;
				busy_len = $random(seed) & 3;
				repeat (busy_len) begin
					s_wb_bsy_i = 1'b1;
					@(posedge clk_i);
					#1;
				end
				s_wb_bsy_i = 1'b0;
				@(posedge clk_i);
				#1;
				check_true(!s_wb_stb_o && s_wb_cyc_o, "slave strobe not dropped once busy fell");
				if (s_wb_we_o)
					mem[s_wb_addr_o] = apply_sel(mem[s_wb_addr_o], s_wb_dat_o, s_wb_sel_o);
				else
					s_wb_dat_i = mem[s_wb_addr_o];
				s_wb_ack_i = 1'b1;
				@(posedge clk_i);
				#1;
				s_wb_ack_i = 1'b0;
			end
		end
	end

	// One master request from issue to ack. Cycles count from the accepting edge.
	task automatic run_access(input logic we, input logic [ADDR_W-1:0] addr,
		input logic [SEL_W-1:0] sel, input logic [ARCH_W-1:0] dat, input logic conly,
		input logic cmiss, output logic [ARCH_W-1:0] rdat, output int cycles);
		@(posedge clk_i);
		#1;
		while (m_wb_bsy_o) begin
			@(posedge clk_i);
			#1;
		end
		m_wb_cyc_i  = 1'b1;
		m_wb_stb_i  = 1'b1;
		m_wb_we_i   = we;
		m_wb_addr_i = addr;
		m_wb_sel_i  = sel;
		m_wb_dat_i  = dat;
		conly_i     = conly;
		cmiss_i     = cmiss;
		@(posedge clk_i); // Accepting edge.
		#1;
		m_wb_stb_i = 1'b0;
		cycles     = 0;
		do begin
			@(negedge clk_i);
			cycles++;
		end while (!m_wb_ack_o);
		rdat = m_wb_dat_o;
		if (we && !conly)
			shadow[addr] = apply_sel(shadow[addr], dat, sel);
		@(posedge clk_i);
		#1;
		check_true(!m_wb_ack_o, "master ack lasted more than one cycle");
		m_wb_cyc_i = 1'b0;
		m_wb_we_i  = 1'b0;
		conly_i    = 1'b0;
		cmiss_i    = 1'b0;
	endtask

	task automatic reset_sweep();
		logic [ARCH_W-1:0] rd;
		logic [ADDR_W-1:0] addr;
		int                cyc;
		int                n0;
		rst_i = 1'b1;
		repeat (3) @(posedge clk_i);
		#1;
		rst_i = 1'b0;
		cyc   = 0;
		check_true(!m_wb_ack_o && !s_wb_cyc_o && !s_wb_stb_o, "bus outputs active after reset");
		while (m_wb_bsy_o) begin
			@(posedge clk_i);
			#1;
			cyc++;
		end
		check_cycles(cyc, SET_COUNT, "busy cycles of the sweep");
		for (int s = 0; s < SET_COUNT; s++) begin
			addr = SET_BASE + ADDR_W'(s);
			n0   = slave_cnt;
			run_access(1'b0, addr, '1, '0, 1'b0, 1'b0, rd, cyc);
			check_cycles(slave_cnt - n0, 1, "slave cycles of a refill");
			check_true(!log_we[n0], "refill issued a slave write");
			check_addr(log_addr[n0], addr, "refill address");
			check_sel(log_sel[n0], '1, "refill selects");
			check_dat(rd, init_word(addr), "refilled read data");
		end
	endtask

	task automatic read_hit();
		logic [ARCH_W-1:0] rd;
		int                cyc;
		int                n0;
		n0 = slave_cnt;
		run_access(1'b0, SET_BASE, '1, '0, 1'b0, 1'b0, rd, cyc);
		check_cycles(cyc, 2, "read hit latency");
		check_cycles(slave_cnt - n0, 0, "slave cycles of a read hit");
		check_dat(rd, init_word(SET_BASE), "read hit data");
	endtask

	task automatic write_merge();
		logic [ARCH_W-1:0] rd;
		int                cyc;
		int                n0;
		n0 = slave_cnt;
		run_access(1'b1, ADDR_A1, 2'b10, 16'hbeef, 1'b0, 1'b0, rd, cyc);
		check_cycles(cyc, 2, "write hit latency");
		run_access(1'b0, ADDR_A1, '1, '0, 1'b0, 1'b0, rd, cyc);
		check_cycles(cyc, 2, "latency of a read after a write hit");
		check_dat(rd, apply_sel(init_word(ADDR_A1), 16'hbeef, 2'b10), "merged read data");
		run_access(1'b1, ADDR_B2, 2'b01, 16'h1234, 1'b0, 1'b0, rd, cyc);
		check_cycles(cyc, 2, "allocating write latency");
		check_cycles(slave_cnt - n0, 0, "slave cycles of hits and allocation");
		// Upper byte is not held yet and comes from memory.
		run_access(1'b0, ADDR_B2, '1, '0, 1'b0, 1'b0, rd, cyc);
		check_cycles(slave_cnt - n0, 1, "slave cycles of a partial refill");
		check_dat(rd, apply_sel(init_word(ADDR_B2), 16'h1234, 2'b01), "allocated read data");
	endtask

	task automatic eviction();
		logic [ARCH_W-1:0] rd;
		logic [ARCH_W-1:0] m1;
		int                cyc;
		int                n0;
		m1 = apply_sel(init_word(ADDR_A1), 16'hbeef, 2'b10);
		n0 = slave_cnt;
		run_access(1'b0, ADDR_C1, '1, '0, 1'b0, 1'b0, rd, cyc);
		check_cycles(slave_cnt - n0, 2, "slave cycles of eviction and refill");
		check_true(log_we[n0] && !log_we[n0+1], "eviction did not write before the refill");
		check_addr(log_addr[n0], ADDR_A1, "eviction address");
		check_sel(log_sel[n0], '1, "eviction selects");
		check_dat(log_dat[n0], m1, "eviction data");
		check_addr(log_addr[n0+1], ADDR_C1, "refill address after eviction");
		check_dat(rd, init_word(ADDR_C1), "read data after eviction");
		check_dat(mem[ADDR_A1], m1, "memory word after eviction");
		n0 = slave_cnt;
		run_access(1'b1, ADDR_D2, 2'b10, 16'h5a00, 1'b0, 1'b0, rd, cyc);
		check_cycles(slave_cnt - n0, 1, "slave cycles of a write eviction");
		check_addr(log_addr[n0], ADDR_B2, "write eviction address");
		check_dat(log_dat[n0], apply_sel(init_word(ADDR_B2), 16'h1234, 2'b01),
			"write eviction data");
	endtask

	task automatic mode_access();
		logic [ARCH_W-1:0] rd;
		int                cyc;
		int                n0;
		n0 = slave_cnt;
		run_access(1'b1, ADDR_E3, '1, 16'hc0de, 1'b1, 1'b0, rd, cyc);
		check_cycles(cyc, 2, "SRAM mode write latency");
		run_access(1'b0, ADDR_E3, '1, '0, 1'b1, 1'b0, rd, cyc);
		check_cycles(cyc, 2, "SRAM mode read latency");
		check_dat(rd, 16'hc0de, "SRAM mode read data");
		check_cycles(slave_cnt - n0, 0, "slave cycles in SRAM mode");
		n0 = slave_cnt;
		run_access(1'b0, ADDR_F3, 2'b01, '0, 1'b0, 1'b1, rd, cyc);
		check_cycles(slave_cnt - n0, 1, "slave cycles of a bypass read");
		check_addr(log_addr[n0], ADDR_F3, "bypass address");
		check_sel(log_sel[n0], 2'b01, "bypass selects");
		check_dat(rd, init_word(ADDR_F3), "bypass read data");
		run_access(1'b0, ADDR_F3, '1, '0, 1'b0, 1'b0, rd, cyc);
		check_cycles(slave_cnt - n0, 2, "slave cycles of the read after bypass");
		check_dat(rd, init_word(ADDR_F3), "read data after bypass");
	endtask

	task automatic back_pressure();
		logic [31:0]       stim [24];
		logic [ARCH_W-1:0] rd;
		logic [ADDR_W-1:0] addr;
		logic [SEL_W-1:0]  sel;
		int                cyc;
		// Drawn while the memory model is idle, so the sequence is fixed.
		for (int i = 0; i < 24; i++)
			stim[i] = $random(seed);
		for (int i = 0; i < 24; i++) begin
			addr = 15'h0400 + ADDR_W'(stim[i][3:0]);
			sel  = (stim[i][6:5] == '0) ? '1 : stim[i][6:5];
			if (stim[i][4]) begin
				run_access(1'b1, addr, sel, stim[i][31:16], 1'b0, 1'b0, rd, cyc);
			end else begin
				run_access(1'b0, addr, '1, '0, 1'b0, 1'b0, rd, cyc);
				check_dat(rd, shadow[addr], "read data under slave busy");
			end
		end
	endtask

	initial begin
		rst_i       = 1'b1;
		conly_i     = 1'b0;
		cmiss_i     = 1'b0;
		m_wb_cyc_i  = 1'b0;
		m_wb_stb_i  = 1'b0;
		m_wb_we_i   = 1'b0;
		m_wb_addr_i = '0;
		m_wb_sel_i  = '0;
		m_wb_dat_i  = '0;
		reset_sweep();
		read_hit();
		write_merge();
		eviction();
		mode_access();
		back_pressure();
		if (uut.u_asserts.fail_cnt == 0) begin
			$display("Testbench passed");
			$finish;
		end else begin
			$display("Protocol assertions failed %0d times", uut.u_asserts.fail_cnt);
			abort_run();
		end
	end

endmodule

// ==== testbench/dcache_asserts.sv ====
//**************************************************************************
// Bus protocol checks for the data cache.
// Bound to the cache top level.
//**************************************************************************

`timescale 1ns/1ps

module dcache_asserts (
	input logic clk_i,
	input logic rst_i,
	input logic m_wb_bsy_o,
	input logic m_wb_ack_o,
	input logic s_wb_cyc_o,
	input logic s_wb_stb_o,
	input logic s_wb_ack_i
);
	int fail_cnt = 0; // Failures so far, watched by the testbench.

	stb_in_cyc: assert property (@(posedge clk_i) disable iff (rst_i)
		s_wb_stb_o |-> s_wb_cyc_o)
		else begin
			fail_cnt++;
			$error("Slave strobe high without cycle.");
		end

	ack_one_cycle: assert property (@(posedge clk_i) disable iff (rst_i)
		m_wb_ack_o |=> !m_wb_ack_o)
		else begin
			fail_cnt++;
			$error("Master ack held for more than one cycle.");
		end

	ack_after_busy: assert property (@(posedge clk_i) disable iff (rst_i)
		m_wb_ack_o |-> $past(m_wb_bsy_o))
		else begin
			fail_cnt++;
			$error("Master ack without a request in progress.");
		end

	cyc_until_ack: assert property (@(posedge clk_i) disable iff (rst_i)
		s_wb_cyc_o && !s_wb_ack_i |=> s_wb_cyc_o)
		else begin
			fail_cnt++;
			$error("Slave cycle dropped before ack.");
		end

endmodule

bind dcache_top dcache_asserts u_asserts (.*);

// ==== verilog/dcache_top.sv ====
//**************************************************************************
// Direct mapped write-back data cache.
// Controller, entry store and memory bus sequencer.
//**************************************************************************

`timescale 1ns/1ps

module dcache_top (
	input  logic                          clk_i,
	input  logic                          rst_i,
	input  logic                          conly_i,
	input  logic                          cmiss_i,
	input  logic                          m_wb_cyc_i,
	input  logic                          m_wb_stb_i,
	input  logic                          m_wb_we_i,
	input  logic [dcache_pkg::ADDR_W-1:0] m_wb_addr_i,
	input  logic [dcache_pkg::SEL_W-1:0]  m_wb_sel_i,
	input  logic [dcache_pkg::ARCH_W-1:0] m_wb_dat_i,
	output logic                          m_wb_bsy_o,
	output logic                          m_wb_ack_o,
	output logic [dcache_pkg::ARCH_W-1:0] m_wb_dat_o,
	output logic                          s_wb_cyc_o,
	output logic                          s_wb_stb_o,
	output logic                          s_wb_we_o,
	output logic [dcache_pkg::ADDR_W-1:0] s_wb_addr_o,
	output logic [dcache_pkg::SEL_W-1:0]  s_wb_sel_o,
	output logic [dcache_pkg::ARCH_W-1:0] s_wb_dat_o,
	input  logic                          s_wb_bsy_i,
	input  logic                          s_wb_ack_i,
	input  logic [dcache_pkg::ARCH_W-1:0] s_wb_dat_i
);

	lookup_if lk_if ();
	mbus_if   mb_if ();

	dcache_ctrl u_ctrl (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.conly_i     (conly_i),
		.cmiss_i     (cmiss_i),
		.m_wb_cyc_i  (m_wb_cyc_i),
		.m_wb_stb_i  (m_wb_stb_i),
		.m_wb_we_i   (m_wb_we_i),
		.m_wb_addr_i (m_wb_addr_i),
		.m_wb_sel_i  (m_wb_sel_i),
		.m_wb_dat_i  (m_wb_dat_i),
		.m_wb_bsy_o  (m_wb_bsy_o),
		.m_wb_ack_o  (m_wb_ack_o),
		.m_wb_dat_o  (m_wb_dat_o),
		.lk          (lk_if.ctrl),
		.mb          (mb_if.ctrl)
	);

	dcache_lookup u_lookup (
		.clk_i (clk_i),
		.rst_i (rst_i),
		.lk    (lk_if.store)
	);

	dcache_bus u_bus (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.mb          (mb_if.bus),
		.s_wb_cyc_o  (s_wb_cyc_o),
		.s_wb_stb_o  (s_wb_stb_o),
		.s_wb_we_o   (s_wb_we_o),
		.s_wb_addr_o (s_wb_addr_o),
		.s_wb_sel_o  (s_wb_sel_o),
		.s_wb_dat_o  (s_wb_dat_o),
		.s_wb_bsy_i  (s_wb_bsy_i),
		.s_wb_ack_i  (s_wb_ack_i),
		.s_wb_dat_i  (s_wb_dat_i)
	);

endmodule

// ==== verilog/dcache_ctrl.sv ====
//**************************************************************************
// Data cache controller.
// Accepts master requests and chooses between hit, allocation,
// eviction, refill and bypass, then acknowledges the master.
//**************************************************************************

`timescale 1ns/1ps

module dcache_ctrl (
	input  logic                          clk_i,
	input  logic                          rst_i,
	input  logic                          conly_i,
	input  logic                          cmiss_i,
	input  logic                          m_wb_cyc_i,
	input  logic                          m_wb_stb_i,
	input  logic                          m_wb_we_i,
	input  logic [dcache_pkg::ADDR_W-1:0] m_wb_addr_i,
	input  logic [dcache_pkg::SEL_W-1:0]  m_wb_sel_i,
	input  logic [dcache_pkg::ARCH_W-1:0] m_wb_dat_i,
	output logic                          m_wb_bsy_o,
	output logic                          m_wb_ack_o,
	output logic [dcache_pkg::ARCH_W-1:0] m_wb_dat_o,
	lookup_if.ctrl                        lk,
	mbus_if.ctrl                          mb
);
	import dcache_pkg::*;

	ctrl_state_e state;
	ctrl_state_e next_state;

	logic [IDX_W-1:0]  sweep_idx;
	logic              acc;
	logic              finish;

	logic              we_r;
	logic [ADDR_W-1:0] addr_r;
	logic [SEL_W-1:0]  sel_r;
	logic [ARCH_W-1:0] dat_r;
	logic              conly_r;
	logic              cmiss_r;

	assign acc = (state == IDLE) && m_wb_cyc_i && m_wb_stb_i && !m_wb_bsy_o;

	// Entry is read at the accepting edge.
	assign lk.rd_stb  = acc;
	assign lk.rd_idx  = m_wb_addr_i[IDX_W-1:0];
	assign lk.req_tag = addr_r[ADDR_W-1:IDX_W];
	assign lk.wr_tag  = addr_r[ADDR_W-1:IDX_W];
	assign lk.wr_idx  = (state == INIT) ? sweep_idx : addr_r[IDX_W-1:0];
	assign lk.m_sel   = sel_r;
	assign lk.m_dat   = dat_r;
	assign lk.mem_dat = mb.rdat;

	always_comb begin
		next_state  = state;
		finish      = 1'b0;
		lk.wr_en    = 1'b0;
		lk.wr_sel   = '0;   // Zero selects invalidate.
		lk.wr_dirty = 1'b0;
		lk.wr_src   = 1'b0;
		mb.start    = 1'b0;
		mb.we       = we_r;
		mb.addr     = addr_r;
		mb.sel      = sel_r;
		mb.dat      = dat_r;
		case (state)
			INIT: begin
				lk.wr_en = 1'b1;
				if (sweep_idx == IDX_W'(SET_COUNT - 1))
					next_state = IDLE;
			end
			IDLE: begin
				if (acc)
					next_state = TESTHIT;
			end
			TESTHIT: begin
				if (conly_r) begin
					lk.wr_en = we_r; // Entry stays invalid in SRAM mode.
					finish   = 1'b1;
				end else if (cmiss_r) begin
					mb.start   = 1'b1;
					next_state = REFILL;
				end else if (lk.full_hit || (lk.tag_hit && we_r)) begin
					lk.wr_en    = we_r;
					lk.wr_sel   = sel_r | lk.ent_sel;
					lk.wr_dirty = 1'b1;
					finish      = 1'b1;
				end else if (lk.ent_dirty && !lk.tag_hit) begin
					mb.start   = 1'b1;
					mb.we      = 1'b1;
					mb.addr    = {lk.ent_tag, addr_r[IDX_W-1:0]};
					mb.sel     = lk.ent_sel;
					mb.dat     = lk.ent_dat;
					next_state = EVICT;
				end else if (we_r) begin
					lk.wr_en    = 1'b1; // Allocate without memory access.
					lk.wr_sel   = sel_r;
					lk.wr_dirty = 1'b1;
					finish      = 1'b1;
				end else begin
					mb.start   = 1'b1;
					mb.we      = 1'b0;
					mb.sel     = '1;
					next_state = REFILL;
				end
			end
			EVICT: begin
				if (mb.done && we_r) begin
					lk.wr_en    = 1'b1;
					lk.wr_sel   = sel_r;
					lk.wr_dirty = 1'b1;
					finish      = 1'b1;
				end else if (mb.done) begin
					mb.start   = 1'b1;
					mb.we      = 1'b0;
					mb.sel     = '1;
					next_state = REFILL;
				end
			end
			REFILL: begin
				if (mb.done) begin
					lk.wr_src = 1'b1;
					finish    = 1'b1;
					if (cmiss_r) begin
						lk.wr_en = lk.tag_hit; // Drop any copy of the bypassed word.
					end else begin
						lk.wr_en    = 1'b1;
						lk.wr_sel   = '1;
						lk.wr_dirty = lk.tag_hit;
					end
				end
			end
			default: next_state = IDLE;
		endcase
		if (finish)
			next_state = IDLE;
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state      <= INIT;
			sweep_idx  <= '0;
			m_wb_bsy_o <= 1'b1;
			m_wb_ack_o <= 1'b0;
			conly_r    <= 1'b0;
			cmiss_r    <= 1'b0;
		end else begin
			state      <= next_state;
			m_wb_ack_o <= finish;
			if (state == INIT) begin
				sweep_idx <= sweep_idx + 1'b1;
				if (next_state == IDLE)
					m_wb_bsy_o <= 1'b0;
			end
			if (acc) begin
				m_wb_bsy_o <= 1'b1;
				conly_r    <= conly_i;
				cmiss_r    <= cmiss_i;
			end
			if (finish)
				m_wb_bsy_o <= 1'b0;
		end
	end

	always_ff @(posedge clk_i) begin
		if (acc) begin
			we_r   <= m_wb_we_i;
			addr_r <= m_wb_addr_i;
			sel_r  <= m_wb_sel_i;
			dat_r  <= m_wb_dat_i;
		end
		if (finish && !we_r)
			m_wb_dat_o <= (state == TESTHIT) ? lk.ent_dat :
				(cmiss_r ? mb.rdat : lk.merged_dat);
	end

endmodule

// ==== verilog/dcache_bus.sv ====
//**************************************************************************
// Data cache memory-side bus sequencer.
// Runs one bus cycle per start pulse, honours slave busy, returns data.
//**************************************************************************

`timescale 1ns/1ps

module dcache_bus (
	input  logic                          clk_i,
	input  logic                          rst_i,
	mbus_if.bus                           mb,
	output logic                          s_wb_cyc_o,
	output logic                          s_wb_stb_o,
	output logic                          s_wb_we_o,
	output logic [dcache_pkg::ADDR_W-1:0] s_wb_addr_o,
	output logic [dcache_pkg::SEL_W-1:0]  s_wb_sel_o,
	output logic [dcache_pkg::ARCH_W-1:0] s_wb_dat_o,
	input  logic                          s_wb_bsy_i,
	input  logic                          s_wb_ack_i,
	input  logic [dcache_pkg::ARCH_W-1:0] s_wb_dat_i
);

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			s_wb_cyc_o <= 1'b0;
			s_wb_stb_o <= 1'b0;
			mb.done    <= 1'b0;
		end else begin
			mb.done <= 1'b0;
			if (mb.start) begin
				s_wb_cyc_o <= 1'b1;
				s_wb_stb_o <= 1'b1;
			end else if (s_wb_cyc_o) begin
				if (s_wb_ack_i) begin
					s_wb_cyc_o <= 1'b0;
					s_wb_stb_o <= 1'b0;
					mb.done    <= 1'b1;
				end else if (!s_wb_bsy_i) begin
					s_wb_stb_o <= 1'b0; // Request taken by the slave.
				end
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (mb.start) begin
			s_wb_we_o   <= mb.we;
			s_wb_addr_o <= mb.addr;
			s_wb_sel_o  <= mb.sel;
			s_wb_dat_o  <= mb.dat;
		end
		if (s_wb_cyc_o && s_wb_ack_i) begin
			mb.rdat <= s_wb_dat_i;
		end
	end

endmodule

// ==== verilog/dcache_lookup.sv ====
//**************************************************************************
// Data cache entry store.
// Tag, byte-valid, data and dirty arrays with a registered read port,
// hit detection and byte merging of the written word.
//**************************************************************************

`timescale 1ns/1ps

module dcache_lookup (
	input logic     clk_i,
	input logic     rst_i,
	lookup_if.store lk
);
	import dcache_pkg::*;

	logic [TAG_W-1:0]  tag_mem   [SET_COUNT];
	logic [SEL_W-1:0]  sel_mem   [SET_COUNT];
	logic [ARCH_W-1:0] dat_mem   [SET_COUNT];
	logic              dirty_mem [SET_COUNT];

	logic [ARCH_W-1:0] m_mask;
	logic [ARCH_W-1:0] ent_mask;

	// Byte selects widened to a bit mask.
	function automatic logic [ARCH_W-1:0] byte_mask(input logic [SEL_W-1:0] sel);
		logic [ARCH_W-1:0] mask;
		for (int i = 0; i < SEL_W; i++) begin
			mask[i*8 +: 8] = {8{sel[i]}};
		end
		return mask;
	endfunction

	always_ff @(posedge clk_i) begin
		if (lk.rd_stb) begin
			lk.ent_tag <= tag_mem[lk.rd_idx];
			lk.ent_dat <= dat_mem[lk.rd_idx];
		end
	end

	// Valid and dirty of the read entry start out cleared.
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			lk.ent_sel   <= '0;
			lk.ent_dirty <= 1'b0;
		end else if (lk.rd_stb) begin
			lk.ent_sel   <= sel_mem[lk.rd_idx];
			lk.ent_dirty <= dirty_mem[lk.rd_idx];
		end
	end

	always_ff @(posedge clk_i) begin
		if (lk.wr_en) begin
			tag_mem[lk.wr_idx]   <= lk.wr_tag;
			sel_mem[lk.wr_idx]   <= lk.wr_sel;
			dat_mem[lk.wr_idx]   <= lk.merged_dat;
			dirty_mem[lk.wr_idx] <= lk.wr_dirty;
		end
	end

	assign m_mask   = byte_mask(lk.m_sel);
	assign ent_mask = byte_mask(lk.ent_sel);

	assign lk.tag_hit  = (lk.ent_tag == lk.req_tag) && (lk.ent_sel != '0);
	assign lk.full_hit = lk.tag_hit && ((lk.m_sel & lk.ent_sel) == lk.m_sel);

	always_comb begin
		if (!lk.wr_src) begin
			lk.merged_dat = (lk.m_dat & m_mask) | (lk.ent_dat & ~m_mask);
		end else if (lk.tag_hit) begin
			// Bytes already held in the entry win over memory.
			lk.merged_dat = (lk.ent_dat & ent_mask) | (lk.mem_dat & ~ent_mask);
		end else begin
			lk.merged_dat = lk.mem_dat;
		end
	end

endmodule

// ==== verilog/dcache_ifs.sv ====
//**************************************************************************
// Data cache internal interfaces.
// Lookup requests to the entry store and memory-side bus cycle requests.
//**************************************************************************

`timescale 1ns/1ps

interface lookup_if;
	import dcache_pkg::*;

	logic              rd_stb;
	logic [IDX_W-1:0]  rd_idx;
	logic              wr_en;
	logic [IDX_W-1:0]  wr_idx;
	logic [TAG_W-1:0]  wr_tag;
	logic [SEL_W-1:0]  wr_sel;
	logic              wr_dirty;
	logic              wr_src;     // 0 merges master data, 1 merges memory data.
	logic [SEL_W-1:0]  m_sel;
	logic [ARCH_W-1:0] m_dat;
	logic [ARCH_W-1:0] mem_dat;
	logic [TAG_W-1:0]  req_tag;

	logic [TAG_W-1:0]  ent_tag;
	logic [SEL_W-1:0]  ent_sel;
	logic [ARCH_W-1:0] ent_dat;
	logic              ent_dirty;
	logic              tag_hit;
	logic              full_hit;
	logic [ARCH_W-1:0] merged_dat;

	modport ctrl (
		output rd_stb, rd_idx, wr_en, wr_idx, wr_tag, wr_sel, wr_dirty, wr_src,
		output m_sel, m_dat, mem_dat, req_tag,
		input  ent_tag, ent_sel, ent_dat, ent_dirty, tag_hit, full_hit, merged_dat
	);

	modport store (
		input  rd_stb, rd_idx, wr_en, wr_idx, wr_tag, wr_sel, wr_dirty, wr_src,
		input  m_sel, m_dat, mem_dat, req_tag,
		output ent_tag, ent_sel, ent_dat, ent_dirty, tag_hit, full_hit, merged_dat
	);
endinterface

interface mbus_if;
	import dcache_pkg::*;

	logic              start;
	logic              we;
	logic [ADDR_W-1:0] addr;
	logic [SEL_W-1:0]  sel;
	logic [ARCH_W-1:0] dat;
	logic              done;
	logic [ARCH_W-1:0] rdat;   // Memory data captured on ack.

	modport ctrl (output start, we, addr, sel, dat, input done, rdat);
	modport bus (input start, we, addr, sel, dat, output done, rdat);
endinterface

// ==== verilog/dcache_pkg.sv ====
//**************************************************************************
// Data cache shared definitions.
// Fixed cache geometry and the controller state encoding.
//**************************************************************************

package dcache_pkg;

	// Word geometry.
	localparam int ARCH_W = 16;
	localparam int SEL_W  = ARCH_W / 8;
	localparam int ADDR_W = ARCH_W - $clog2(SEL_W); // Word address.

	// Direct mapped, one word per entry.
	localparam int SET_COUNT = 4;
	localparam int IDX_W     = $clog2(SET_COUNT);
	localparam int TAG_W     = ADDR_W - IDX_W;

	typedef enum logic [2:0] {
		INIT,    // Clearing entries after reset.
		IDLE,
		TESTHIT,
		EVICT,   // Writing back a dirty entry.
		REFILL   // Memory read, or bypass cycle.
	} ctrl_state_e;

endpackage
